/* scadPkg.sv */
package scadPkg;

  // SCAD, FE and SC share one width
  localparam int scadWidth = 10;

  // Full AR word
  localparam int arWidth = 36;

  // Microword magic number field
  localparam int magicWidth = 9;

  // SCAD function select
  // The encoding follows the CRAM SCAD field, so the adder
  // decodes carry-in and B complement straight from it
  typedef enum logic [2:0] {
    // A passed through
    scadPassA         = 3'd0,
    // A plus complement of B without carry in
    scadAMinusBMinus1 = 3'd1,
    scadAPlusB        = 3'd2,
    // A plus all ones
    scadAMinus1       = 3'd3,
    // Carry in only
    scadAPlus1        = 3'd4,
    // A plus complement of B with carry in
    scadAMinusB       = 3'd5,
    scadOr            = 3'd6,
    scadAnd           = 3'd7
  } scadOpE;

endpackage

/* cramPkg.sv */
package cramPkg;

  // SCAD A operand source gated separately by the A enable bit
  typedef enum logic [1:0] {
    aSelFe    = 2'd0,
    // Byte position from AR 0..5
    aSelArPos = 2'd1,
    // Magnitude of the AR exponent
    aSelArExp = 2'd2,
    aSelMagic = 2'd3
  } scadASelE;

  // SCAD B operand source
  typedef enum logic [1:0] {
    bSelSc       = 2'd0,
    // Byte size from AR 6..11
    bSelArSize   = 2'd1,
    // AR 0..8 taken as a signed value
    bSelArExpRaw = 2'd2,
    bSelMagic    = 2'd3
  } scadBSelE;

  // SC load source
  typedef enum logic [1:0] {
    scSelHold    = 2'd0,
    scSelFe      = 2'd1,
    scSelScad    = 2'd2,
    // Count field of AR right half
    scSelArCount = 2'd3
  } scSelE;

endpackage

/* scdOperandMux.sv */
`timescale 1ns/1ps

module scdOperandMux (
  input  logic [0:scadPkg::arWidth-1]    ar,
  input  logic [0:scadPkg::magicWidth-1] magic,
  input  logic [0:scadPkg::scadWidth-1]  fe,
  input  logic [0:scadPkg::scadWidth-1]  sc,
  input  cramPkg::scadASelE              scadASel,
  input  logic                           scadAEn,
  input  cramPkg::scadBSelE              scadBSel,
  output logic [0:scadPkg::scadWidth-1]  scadA,
  output logic [0:scadPkg::scadWidth-1]  scadB
);

  // Number of bits the sign is replicated into for a 9 bit field
  localparam int signPad = scadPkg::scadWidth - scadPkg::magicWidth;

  // Position and size fields are 6 bits wide
  localparam int byteFieldWidth = 6;
  localparam int bytePad = scadPkg::scadWidth - byteFieldWidth;

  // Exponent lives in AR 1..8
  localparam int expWidth = 8;
  localparam int expPad = scadPkg::scadWidth - expWidth;

  logic [0:scadPkg::scadWidth-1] arPos;
  logic [0:scadPkg::scadWidth-1] arSize;
  logic [0:scadPkg::scadWidth-1] arExp;
  logic [0:scadPkg::scadWidth-1] arExpRaw;
  logic [0:scadPkg::scadWidth-1] magicExt;
  logic [0:expWidth-1]           expMag;
  logic [0:scadPkg::scadWidth-1] aSelected;

  // Negative words keep the exponent complemented
  assign expMag = ar[1:expWidth] ^ {expWidth{ar[0]}};

  assign arExp = {{expPad{1'b0}}, expMag};

  // Byte pointer fields
  assign arPos  = {{bytePad{1'b0}}, ar[0:byteFieldWidth-1]};
  assign arSize = {{bytePad{1'b0}}, ar[byteFieldWidth:2*byteFieldWidth-1]};

  assign arExpRaw = {{signPad{ar[0]}}, ar[0:scadPkg::magicWidth-1]};

  assign magicExt = {{signPad{magic[0]}}, magic};

  always_comb begin
    case (scadASel)
      cramPkg::aSelFe: begin
        aSelected = fe;
      end
      cramPkg::aSelArPos: begin
        aSelected = arPos;
      end
      cramPkg::aSelArExp: begin
        aSelected = arExp;
      end
      default: begin
        aSelected = magicExt;
      end
    endcase
  end

  // A side is forced to zero when not enabled
  assign scadA = scadAEn ? aSelected : '0;

  always_comb begin
    case (scadBSel)
      cramPkg::bSelSc: begin
        scadB = sc;
      end
      cramPkg::bSelArSize: begin
        scadB = arSize;
      end
      cramPkg::bSelArExpRaw: begin
        scadB = arExpRaw;
      end
      default: begin
        scadB = magicExt;
      end
    endcase
  end

endmodule

/* scadAlu.sv */
`timescale 1ns/1ps

module scadAlu (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [0:scadPkg::scadWidth-1] scadA,
  input  logic [0:scadPkg::scadWidth-1] scadB,
  input  scadPkg::scadOpE               scadOp,
  output logic [0:scadPkg::scadWidth-1] scad,
  output logic                          scadZero,
  output logic                          scadSign
);

  logic [0:scadPkg::scadWidth-1] addend;
  logic                          carryIn;
  logic [0:scadPkg::scadWidth-1] carryVec;
  logic [0:scadPkg::scadWidth-1] sum;

  // Adder B input and carry in per function
  // Subtraction adds the complement of B and the carry in makes a true difference
  always_comb begin
    addend  = '0;
    carryIn = 1'b0;
    case (scadOp)
      scadPkg::scadAMinusBMinus1: begin
        addend = ~scadB;
      end
      scadPkg::scadAPlusB: begin
        addend = scadB;
      end
      scadPkg::scadAMinus1: begin
        addend = '1;
      end
      scadPkg::scadAPlus1: begin
        carryIn = 1'b1;
      end
      scadPkg::scadAMinusB: begin
        addend  = ~scadB;
        carryIn = 1'b1;
      end
      default: begin
        // Pass A and the boolean functions add nothing
        addend  = '0;
        carryIn = 1'b0;
      end
    endcase
  end

  assign carryVec = {{(scadPkg::scadWidth - 1){1'b0}}, carryIn};

  // Carry out of bit 0 is dropped so results wrap
  assign sum = scadA + addend + carryVec;

  always_comb begin
    case (scadOp)
      scadPkg::scadOr: begin
        scad = scadA | scadB;
      end
      scadPkg::scadAnd: begin
        scad = scadA & scadB;
      end
      default: begin
        scad = sum;
      end
    endcase
  end

  assign scadZero = scad == '0;
  assign scadSign = scad[0];

  // Microword function must be known every running cycle
  scadOpKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    !$isunknown(scadOp)
  ) else $error("scadAlu: unknown SCAD function %b", scadOp);

endmodule

/* scdRegisters.sv */
`timescale 1ns/1ps

module scdRegisters (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [0:scadPkg::scadWidth-1] scad,
  input  logic [0:scadPkg::arWidth-1]   ar,
  input  logic                          feLoad,
  input  cramPkg::scSelE                scSel,
  output logic [0:scadPkg::scadWidth-1] fe,
  output logic [0:scadPkg::scadWidth-1] sc,
  output logic                          scIn36To63,
  output logic                          scAbove63
);

  // Count field sits in AR 28..35 with its sign from AR 18
  localparam int countLow = 28;
  localparam int countSign = 18;
  localparam int countPad = scadPkg::scadWidth - (scadPkg::arWidth - countLow);

  logic [0:scadPkg::scadWidth-1] arCount;
  logic [0:scadPkg::scadWidth-1] scNext;

  assign arCount = {{countPad{ar[countSign]}}, ar[countLow:scadPkg::arWidth-1]};

  always_comb begin
    case (scSel)
      cramPkg::scSelHold: begin
        scNext = sc;
      end
      cramPkg::scSelFe: begin
        scNext = fe;
      end
      cramPkg::scSelScad: begin
        scNext = scad;
      end
      default: begin
        scNext = arCount;
      end
    endcase
  end

  // Floating exponent register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fe <= '0;
    end else if (feLoad) begin
      fe <= scad;
    end
  end

  // Shift counter
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sc <= '0;
    end else begin
      sc <= scNext;
    end
  end

  // Range decodes used by the shifter
  // Any of the upper four bits means above 63 or negative
  assign scAbove63  = |sc[0:3];
  assign scIn36To63 = sc[4] & |sc[5:7];

  // First edge after release sees the cleared registers
  resetClears: assert property (
    @(posedge clk) disable iff (!arstN)
    $rose(arstN) |-> (fe == '0) && (sc == '0)
  ) else $error("scdRegisters: FE or SC not clear after reset");

  // Idle microword leaves both registers alone
  idleHolds: assert property (
    @(posedge clk) disable iff (!arstN)
    (scSel == cramPkg::scSelHold) && !feLoad |=> $stable(sc) && $stable(fe)
  ) else $error("scdRegisters: FE or SC changed on an idle microword");

endmodule

/* scd.sv */
`timescale 1ns/1ps

module scd (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic [0:scadPkg::arWidth-1]    ar,
  input  logic [0:scadPkg::magicWidth-1] magic,
  input  scadPkg::scadOpE                scadOp,
  input  cramPkg::scadASelE              scadASel,
  input  logic                           scadAEn,
  input  cramPkg::scadBSelE              scadBSel,
  input  logic                           feLoad,
  input  cramPkg::scSelE                 scSel,
  output logic [0:scadPkg::scadWidth-1]  scad,
  output logic                           scadZero,
  output logic                           scadSign,
  output logic [0:scadPkg::scadWidth-1]  fe,
  output logic [0:scadPkg::scadWidth-1]  sc,
  output logic                           scIn36To63,
  output logic                           scAbove63
);

  logic [0:scadPkg::scadWidth-1] scadA;
  logic [0:scadPkg::scadWidth-1] scadB;

  // Operand select from registers, AR and the microword
  scdOperandMux operandMux (
    .ar       (ar),
    .magic    (magic),
    .fe       (fe),
    .sc       (sc),
    .scadASel (scadASel),
    .scadAEn  (scadAEn),
    .scadBSel (scadBSel),
    .scadA    (scadA),
    .scadB    (scadB)
  );

  scadAlu alu (
    .clk      (clk),
    .arstN    (arstN),
    .scadA    (scadA),
    .scadB    (scadB),
    .scadOp   (scadOp),
    .scad     (scad),
    .scadZero (scadZero),
    .scadSign (scadSign)
  );

  // FE and SC close the loop back to the operand mux
  scdRegisters registers (
    .clk        (clk),
    .arstN      (arstN),
    .scad       (scad),
    .ar         (ar),
    .feLoad     (feLoad),
    .scSel      (scSel),
    .fe         (fe),
    .sc         (sc),
    .scIn36To63 (scIn36To63),
    .scAbove63  (scAbove63)
  );

endmodule

/* scdTbCheck.sv */
`timescale 1ns/1ps

module scdTbCheck (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic [0:scadPkg::arWidth-1]    ar,
  input  logic [0:scadPkg::magicWidth-1] magic,
  input  scadPkg::scadOpE                scadOp,
  input  cramPkg::scadASelE              scadASel,
  input  logic                           scadAEn,
  input  cramPkg::scadBSelE              scadBSel,
  input  logic                           feLoad,
  input  cramPkg::scSelE                 scSel,
  input  logic [0:scadPkg::scadWidth-1]  scad,
  input  logic                           scadZero,
  input  logic                           scadSign,
  input  logic [0:scadPkg::scadWidth-1]  fe,
  input  logic [0:scadPkg::scadWidth-1]  sc,
  input  logic                           scIn36To63,
  input  logic                           scAbove63,
  output int                             errors
);

  logic [0:scadPkg::scadWidth-1] feModel;
  logic [0:scadPkg::scadWidth-1] scModel;
  logic [0:scadPkg::scadWidth-1] opA;
  logic [0:scadPkg::scadWidth-1] opB;
  logic [0:scadPkg::scadWidth-1] magicExt;
  logic [0:scadPkg::scadWidth-1] countExt;
  logic [0:scadPkg::scadWidth-1] expScad;
  logic                          expAbove63;
  logic                          expIn36To63;

  initial errors = 0;

  task automatic recordError(input string testName, input logic [0:9] expected,
                             input logic [0:9] actual);
    errors++;
    $display("error %s expected %h actual %h at %0t", testName, expected, actual, $time);
  endtask

  // SCAD functions as listed for the board wrap at 10 bits
  function automatic logic [0:9] applyScadFunction(input scadPkg::scadOpE op,
                                                   input logic [0:9] a, input logic [0:9] b);
    case (op)
      scadPkg::scadPassA:         return a;
      scadPkg::scadAMinusBMinus1: return a - b - 10'd1;
      scadPkg::scadAPlusB:        return a + b;
      scadPkg::scadAMinus1:       return a - 10'd1;
      scadPkg::scadAPlus1:        return a + 10'd1;
      scadPkg::scadAMinusB:       return a - b;
      scadPkg::scadOr:            return a | b;
      default:                    return a & b;
    endcase
  endfunction

  always_comb begin
    magicExt = {magic[0], magic};
    countExt = {ar[18], ar[18], ar[28:35]};
    if (!scadAEn) begin
      opA = '0;
    end else begin
      case (scadASel)
        cramPkg::aSelFe:    opA = feModel;
        cramPkg::aSelArPos: opA = {4'b0, ar[0:5]};
        cramPkg::aSelArExp: opA = {2'b0, ar[1:8] ^ {8{ar[0]}}};
        default:            opA = magicExt;
      endcase
    end
    case (scadBSel)
      cramPkg::bSelSc:       opB = scModel;
      cramPkg::bSelArSize:   opB = {4'b0, ar[6:11]};
      cramPkg::bSelArExpRaw: opB = {ar[0], ar[0:8]};
      default:               opB = magicExt;
    endcase
    expScad = applyScadFunction(scadOp, opA, opB);
    expAbove63 = |scModel[0:3];
    expIn36To63 = scModel[4] & |scModel[5:7];
  end

  // Model copies of FE and SC
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      feModel <= '0;
      scModel <= '0;
    end else begin
      if (feLoad) begin
        feModel <= expScad;
      end
      case (scSel)
        cramPkg::scSelHold:  scModel <= scModel;
        cramPkg::scSelFe:    scModel <= feModel;
        cramPkg::scSelScad:  scModel <= expScad;
        default:             scModel <= countExt;
      endcase
    end
  end

  scadFunction: assert property (@(posedge clk) disable iff (!arstN) scad == expScad)
    else recordError("scadFunction", expScad, scad);

  scadStatus: assert property (@(posedge clk) disable iff (!arstN)
    scadZero == (expScad == '0) && scadSign == expScad[0])
    else recordError("scadStatus", {8'b0, expScad == '0, expScad[0]},
                     {8'b0, scadZero, scadSign});

  feLoadHold: assert property (@(posedge clk) disable iff (!arstN) fe == feModel)
    else recordError("feLoadHold", feModel, fe);

  scSource: assert property (@(posedge clk) disable iff (!arstN) sc == scModel)
    else recordError("scSource", scModel, sc);

  scRange: assert property (@(posedge clk) disable iff (!arstN)
    scAbove63 == expAbove63 && scIn36To63 == expIn36To63)
    else recordError("scRange", {8'b0, expAbove63, expIn36To63},
                     {8'b0, scAbove63, scIn36To63});

  // Checked while in reset and on the first edge after release
  resetClearFe: assert property (@(posedge clk) (!arstN || $rose(arstN)) |-> fe == '0)
    else recordError("resetClear", 10'd0, fe);

  resetClearSc: assert property (@(posedge clk) (!arstN || $rose(arstN)) |-> sc == '0)
    else recordError("resetClear", 10'd0, sc);

endmodule

/* scdTb.sv */
`timescale 1ns/1ps

module scdTb;

  localparam int resetCycles = 2;
  localparam int randomWords = 2000;
  // Covers reset, the random run and the directed words with ample margin
  localparam int cycleLimit = 2500;

  logic                           clk;
  logic                           arstN;
  logic [0:scadPkg::arWidth-1]    ar;
  logic [0:scadPkg::magicWidth-1] magic;
  scadPkg::scadOpE                scadOp;
  cramPkg::scadASelE              scadASel;
  logic                           scadAEn;
  cramPkg::scadBSelE              scadBSel;
  logic                           feLoad;
  cramPkg::scSelE                 scSel;
  logic [0:scadPkg::scadWidth-1]  scad;
  logic                           scadZero;
  logic                           scadSign;
  logic [0:scadPkg::scadWidth-1]  fe;
  logic [0:scadPkg::scadWidth-1]  sc;
  logic                           scIn36To63;
  logic                           scAbove63;
  int                             checkErrors;
  int                             otherErrors = 0;
  int                             cycles;

  scd scd_inst (
    .clk(clk), .arstN(arstN), .ar(ar), .magic(magic), .scadOp(scadOp),
    .scadASel(scadASel), .scadAEn(scadAEn), .scadBSel(scadBSel), .feLoad(feLoad),
    .scSel(scSel), .scad(scad), .scadZero(scadZero), .scadSign(scadSign), .fe(fe),
    .sc(sc), .scIn36To63(scIn36To63), .scAbove63(scAbove63)
  );

  scdTbCheck check (
    .clk(clk), .arstN(arstN), .ar(ar), .magic(magic), .scadOp(scadOp),
    .scadASel(scadASel), .scadAEn(scadAEn), .scadBSel(scadBSel), .feLoad(feLoad),
    .scSel(scSel), .scad(scad), .scadZero(scadZero), .scadSign(scadSign), .fe(fe),
    .sc(sc), .scIn36To63(scIn36To63), .scAbove63(scAbove63), .errors(checkErrors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic driveRandomWord();
    logic [2:0] opBits;
    logic [1:0] aBits;
    logic [1:0] bBits;
    logic [1:0] scBits;
    opBits = 3'($urandom());
    aBits = 2'($urandom());
    bBits = 2'($urandom());
    scBits = 2'($urandom());
    @(posedge clk);
    scadOp <= scadPkg::scadOpE'(opBits);
    scadASel <= cramPkg::scadASelE'(aBits);
    scadBSel <= cramPkg::scadBSelE'(bBits);
    scSel <= cramPkg::scSelE'(scBits);
    scadAEn <= 1'($urandom());
    feLoad <= 1'($urandom());
    ar <= 36'({$urandom(), $urandom()});
    magic <= 9'($urandom());
  endtask

  task automatic driveWord(input scadPkg::scadOpE op, input cramPkg::scadASelE aSel,
                           input logic aEn, input cramPkg::scadBSelE bSel, input logic feLd,
                           input cramPkg::scSelE scS, input logic [0:35] arV,
                           input logic [0:8] magicV);
    @(posedge clk);
    scadOp <= op;
    scadASel <= aSel;
    scadAEn <= aEn;
    scadBSel <= bSel;
    feLoad <= feLd;
    scSel <= scS;
    ar <= arV;
    magic <= magicV;
  endtask

  // FE and SC hold while the rest of the microword stays as it was
  task automatic holdWords(input int count);
    repeat (count) begin
      @(posedge clk);
      feLoad <= 1'b0;
      scSel <= cramPkg::scSelHold;
    end
  endtask

  task automatic loadCount(input logic neg, input logic [7:0] count);
    logic [0:35] word;
    word = '0;
    word[18] = neg;
    word[28:35] = count;
    driveWord(scadPkg::scadPassA, cramPkg::aSelFe, 1'b0, cramPkg::bSelSc, 1'b0,
              cramPkg::scSelArCount, word, 9'h000);
    holdWords(3);
  endtask

  task automatic printCounts();
    $display("assertion errors: %0d, other errors: %0d", checkErrors, otherErrors);
  endtask

  initial begin
    cycles = 0;
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycleLimit);
    otherErrors++;
    printCounts();
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h2409));
    arstN = 1'b0;
    ar = '0;
    magic = '0;
    scadOp = scadPkg::scadPassA;
    scadASel = cramPkg::aSelFe;
    scadAEn = 1'b0;
    scadBSel = cramPkg::bSelSc;
    feLoad = 1'b0;
    scSel = cramPkg::scSelHold;
    // Random microwords keep arriving while reset is held
    repeat (resetCycles) driveRandomWord();
    arstN <= 1'b1;
    repeat (randomWords) driveRandomWord();
    // Equal operands subtract to zero
    driveWord(scadPkg::scadAMinusB, cramPkg::aSelMagic, 1'b1, cramPkg::bSelMagic, 1'b1,
              cramPkg::scSelScad, 36'h5A5A5A5A5, 9'h0A5);
    holdWords(2);
    loadCount(1'b0, 8'd35);
    loadCount(1'b0, 8'd36);
    loadCount(1'b0, 8'd63);
    loadCount(1'b0, 8'd64);
    loadCount(1'b1, 8'hC0);
    loadCount(1'b1, 8'hFF);
    // Negative magic into FE, then FE into SC
    driveWord(scadPkg::scadPassA, cramPkg::aSelMagic, 1'b1, cramPkg::bSelSc, 1'b1,
              cramPkg::scSelHold, 36'h0, 9'h1C3);
    driveWord(scadPkg::scadAPlus1, cramPkg::aSelFe, 1'b1, cramPkg::bSelSc, 1'b0,
              cramPkg::scSelFe, 36'h0, 9'h000);
    holdWords(3);
    repeat (2) @(posedge clk);
    @(negedge clk);
    printCounts();
    if (checkErrors == 0 && otherErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* scd.f */
scadPkg.sv
cramPkg.sv
scdOperandMux.sv
scadAlu.sv
scdRegisters.sv
scd.sv
scdTbCheck.sv
scdTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module scdTb -f scd.f -o scdSim

# The simulation may stop early on an RTL assertion, the log decides
./obj_dir/scdSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
echo "simulation did not pass"
exit 1
